//--- verilog/cdb_defs.svh
`ifndef CDB_DEFS_SVH
`define CDB_DEFS_SVH

////////////////////
// datapath widths
////////////////////

// operands and results
`define DATA_W 32
// reorder tag
`define TAG_W 4

////////////////////
// unit latencies
////////////////////

// issue acceptance to cdb, in cycles
`define ALU_LAT 1
`define MUL_LAT 3

`endif

//--- verilog/isa_pkg.sv
package isa_pkg;

	// opcodes seen on the issue port
	typedef enum logic [1:0] {
		OP_ADD = 2'd0,
		OP_SUB = 2'd1,
		OP_MOV = 2'd2,
		OP_MUL = 2'd3
	} op_t;

	// only OP_MUL goes to the multiplier

endpackage

//--- verilog/cdb_pkg.sv
`include "cdb_defs.svh"

package cdb_pkg;

	// reorder tag carried with each result
	typedef logic [`TAG_W-1:0] tag_t;

	// owner of a reserved write-back slot
	typedef enum logic {
		UNIT_ALU = 1'b0,
		UNIT_MUL = 1'b1
	} unit_t;

	// selects the result mux at stage 0

endpackage

//--- verilog/issue_dispatch.sv
`timescale 1ns/1ns
`include "cdb_defs.svh"

module issue_dispatch (
	input  logic               issue_valid,
	input  isa_pkg::op_t       issue_op,
	input  logic [`DATA_W-1:0] issue_a,
	input  logic [`DATA_W-1:0] issue_b,
	input  cdb_pkg::tag_t      issue_tag,
	output logic               issue_ready,
	input  logic               alu_grant,
	input  logic               mul_grant,
	output logic               alu_req,
	output logic               mul_req,
	output cdb_pkg::tag_t      req_tag,
	output logic               alu_start,
	output logic               mul_start,
	output isa_pkg::op_t       alu_op,
	output logic [`DATA_W-1:0] opnd_a,
	output logic [`DATA_W-1:0] opnd_b
);
	logic to_mul;

	////////////////////
	// decode
	////////////////////

	always_comb begin
		case (issue_op)
			isa_pkg::OP_ADD: to_mul = 1'b0;
			isa_pkg::OP_SUB: to_mul = 1'b0;
			isa_pkg::OP_MOV: to_mul = 1'b0;
			isa_pkg::OP_MUL: to_mul = 1'b1;
			default:         to_mul = 1'b0;
		endcase
	end

	////////////////////
	// slot request
	////////////////////

	// one request, to the decoded unit only
	assign alu_req = issue_valid && !to_mul;
	assign mul_req = issue_valid && to_mul;
	assign req_tag = issue_tag;

	// ready follows the grant of the chosen unit
	assign issue_ready = to_mul ? mul_grant : alu_grant;

	////////////////////
	// unit start
	////////////////////

	// a granted request is the handshake itself
	assign alu_start = alu_req && alu_grant;
	assign mul_start = mul_req && mul_grant;

	assign alu_op = issue_op;
	assign opnd_a = issue_a;
	assign opnd_b = issue_b;

endmodule

//--- verilog/cdb_reservation.sv
`timescale 1ns/1ns
`include "cdb_defs.svh"

module cdb_reservation (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               alu_req,
	input  logic               mul_req,
	input  cdb_pkg::tag_t      req_tag,
	output logic               alu_grant,
	output logic               mul_grant,
	input  logic [`DATA_W-1:0] alu_result,
	input  logic [`DATA_W-1:0] mul_result,
	output logic               cdb_valid,
	output cdb_pkg::tag_t      cdb_tag,
	output logic [`DATA_W-1:0] cdb_data
);
	// stage 0 owns the bus this cycle, the top stage is MUL_LAT-1
	logic [`MUL_LAT-1:0] rsv_vld;
	cdb_pkg::tag_t       rsv_tag  [`MUL_LAT];
	cdb_pkg::unit_t      rsv_unit [`MUL_LAT];

	logic alu_book;
	logic mul_book;

	////////////////////
	// grants
	////////////////////

	// longest unit never waits
	assign mul_grant = 1'b1;

	// alu refused when an older booking lands in its slot
	assign alu_grant = !rsv_vld[`ALU_LAT];

	assign alu_book = alu_req && alu_grant;
	assign mul_book = mul_req && mul_grant;

	////////////////////
	// shift register
	////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rsv_vld <= '0;
		end else begin
			rsv_vld[`MUL_LAT-1] <= mul_book;
			for (int i = 0; i < `MUL_LAT-1; i++) begin
				if (i == `ALU_LAT-1) begin
					rsv_vld[i] <= rsv_vld[i+1] || alu_book;
				end else begin
					rsv_vld[i] <= rsv_vld[i+1];
				end
			end
		end
	end

	// tag and owner ride along with the valid bit
	always_ff @(posedge clk) begin
		rsv_tag[`MUL_LAT-1]  <= req_tag;
		rsv_unit[`MUL_LAT-1] <= cdb_pkg::UNIT_MUL;
		for (int i = 0; i < `MUL_LAT-1; i++) begin
			if (rsv_vld[i+1]) begin
				rsv_tag[i]  <= rsv_tag[i+1];
				rsv_unit[i] <= rsv_unit[i+1];
			end else if (i == `ALU_LAT-1) begin
				// free slot, loaded even without a booking
				rsv_tag[i]  <= req_tag;
				rsv_unit[i] <= cdb_pkg::UNIT_ALU;
			end
		end
	end

	////////////////////
	// result bus
	////////////////////

	assign cdb_valid = rsv_vld[0];
	assign cdb_tag   = rsv_tag[0];

	// owner of stage 0 picks the data
	always_comb begin
		case (rsv_unit[0])
			cdb_pkg::UNIT_MUL: cdb_data = mul_result;
			cdb_pkg::UNIT_ALU: cdb_data = alu_result;
			default:           cdb_data = alu_result;
		endcase
	end

endmodule

//--- verilog/alu_unit.sv
`timescale 1ns/1ns
`include "cdb_defs.svh"

module alu_unit (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               alu_start,
	input  isa_pkg::op_t       alu_op,
	input  logic [`DATA_W-1:0] opnd_a,
	input  logic [`DATA_W-1:0] opnd_b,
	output logic [`DATA_W-1:0] alu_result
);
	logic [`DATA_W-1:0] alu_next;

	////////////////////
	// operation
	////////////////////

	// wraps modulo 2^DATA_W
	always_comb begin
		case (alu_op)
			isa_pkg::OP_ADD: alu_next = opnd_a + opnd_b;
			isa_pkg::OP_SUB: alu_next = opnd_a - opnd_b;
			isa_pkg::OP_MOV: alu_next = opnd_b;
			default:         alu_next = opnd_b;
		endcase
	end

	////////////////////
	// result register
	////////////////////

	// held until the next start, covers the booked slot
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			alu_result <= '0;
		end else if (alu_start) begin
			alu_result <= alu_next;
		end
	end

endmodule

//--- verilog/mul_unit.sv
`timescale 1ns/1ns
`include "cdb_defs.svh"

module mul_unit (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               mul_start,
	input  logic [`DATA_W-1:0] opnd_a,
	input  logic [`DATA_W-1:0] opnd_b,
	output logic [`DATA_W-1:0] mul_result
);
	// stage occupancy, only used to enable the later stages
	logic s1_vld;
	logic s2_vld;

	logic [`DATA_W-1:0] a_q;
	logic [`DATA_W-1:0] b_q;
	logic [`DATA_W-1:0] prod_q;

	////////////////////
	// occupancy
	////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_vld <= 1'b0;
			s2_vld <= 1'b0;
		end else begin
			s1_vld <= mul_start;
			s2_vld <= s1_vld;
		end
	end

	////////////////////
	// datapath
	////////////////////

	// stage 1 operands
	always_ff @(posedge clk) begin
		if (mul_start) begin
			a_q <= opnd_a;
			b_q <= opnd_b;
		end
	end

	// stage 2 product, low half only
	always_ff @(posedge clk) begin
		if (s1_vld) begin
			prod_q <= a_q * b_q;
		end
	end

	// stage 3 drives the bus in the booked slot
	always_ff @(posedge clk) begin
		if (s2_vld) begin
			mul_result <= prod_q;
		end
	end

endmodule

//--- verilog/cdb_core.sv
`timescale 1ns/1ns
`include "cdb_defs.svh"

module cdb_core (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               issue_valid,
	input  isa_pkg::op_t       issue_op,
	input  logic [`DATA_W-1:0] issue_a,
	input  logic [`DATA_W-1:0] issue_b,
	input  cdb_pkg::tag_t      issue_tag,
	output logic               issue_ready,
	output logic               cdb_valid,
	output cdb_pkg::tag_t      cdb_tag,
	output logic [`DATA_W-1:0] cdb_data
);
	// dispatch to reservation
	logic          alu_req;
	logic          mul_req;
	cdb_pkg::tag_t req_tag;
	logic          alu_grant;
	logic          mul_grant;

	// dispatch to units
	logic               alu_start;
	logic               mul_start;
	isa_pkg::op_t       alu_op;
	logic [`DATA_W-1:0] opnd_a;
	logic [`DATA_W-1:0] opnd_b;

	// unit results
	logic [`DATA_W-1:0] alu_result;
	logic [`DATA_W-1:0] mul_result;

	issue_dispatch u_issue_dispatch (
		.issue_valid (issue_valid),
		.issue_op    (issue_op),
		.issue_a     (issue_a),
		.issue_b     (issue_b),
		.issue_tag   (issue_tag),
		.issue_ready (issue_ready),
		.alu_grant   (alu_grant),
		.mul_grant   (mul_grant),
		.alu_req     (alu_req),
		.mul_req     (mul_req),
		.req_tag     (req_tag),
		.alu_start   (alu_start),
		.mul_start   (mul_start),
		.alu_op      (alu_op),
		.opnd_a      (opnd_a),
		.opnd_b      (opnd_b)
	);

	alu_unit u_alu_unit (
		.clk        (clk),
		.arst_n     (arst_n),
		.alu_start  (alu_start),
		.alu_op     (alu_op),
		.opnd_a     (opnd_a),
		.opnd_b     (opnd_b),
		.alu_result (alu_result)
	);

	mul_unit u_mul_unit (
		.clk        (clk),
		.arst_n     (arst_n),
		.mul_start  (mul_start),
		.opnd_a     (opnd_a),
		.opnd_b     (opnd_b),
		.mul_result (mul_result)
	);

	cdb_reservation u_cdb_reservation (
		.clk        (clk),
		.arst_n     (arst_n),
		.alu_req    (alu_req),
		.mul_req    (mul_req),
		.req_tag    (req_tag),
		.alu_grant  (alu_grant),
		.mul_grant  (mul_grant),
		.alu_result (alu_result),
		.mul_result (mul_result),
		.cdb_valid  (cdb_valid),
		.cdb_tag    (cdb_tag),
		.cdb_data   (cdb_data)
	);

endmodule

//--- verif/cdb_core_properties.sv
`timescale 1ns/1ns
`include "cdb_defs.svh"

module cdb_core_properties (
	input logic         clk,
	input logic         arst_n,
	input logic         issue_valid,
	input isa_pkg::op_t issue_op,
	input logic         issue_ready
	,
	input logic         cdb_valid
);
	cdb_pkg::unit_t issue_unit;

	assign issue_unit = (issue_op == isa_pkg::OP_MUL) ? cdb_pkg::UNIT_MUL : cdb_pkg::UNIT_ALU;

	// longest unit never waits
	a_mul_ready: assert property (@(posedge clk) issue_unit == cdb_pkg::UNIT_MUL |-> issue_ready)
		else $error("issue_ready low for a multiplier operation");

	a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !cdb_valid)
		else $error("cdb_valid high during reset");

	// accepted alu op owns the next slot
	a_alu_slot: assert property (@(posedge clk) disable iff (!arst_n)
		issue_valid && issue_ready && issue_unit == cdb_pkg::UNIT_ALU |-> ##`ALU_LAT cdb_valid)
		else $error("accepted alu op did not reach the cdb");

endmodule

bind cdb_core cdb_core_properties u_cdb_core_properties (
	.clk         (clk),
	.arst_n      (arst_n),
	.issue_valid (issue_valid),
	.issue_op    (issue_op),
	.issue_ready (issue_ready),
	.cdb_valid   (cdb_valid)
);

//--- verif/cdb_core_tb.sv
`timescale 1ns/1ns
`include "cdb_defs.svh"

module cdb_core_tb;

	localparam int CLK_PERIOD = 8;
	localparam int RST_CYCLES = 5;
	localparam int MAX_GAP    = 3;
	localparam int DRIVE_DLY  = 1;

	logic               clk;
	logic               arst_n;
	logic               issue_valid;
	isa_pkg::op_t       issue_op;
	logic [`DATA_W-1:0] issue_a;
	logic [`DATA_W-1:0] issue_b;
	cdb_pkg::tag_t      issue_tag;
	logic               issue_ready;
	logic               cdb_valid;
	cdb_pkg::tag_t      cdb_tag;
	logic [`DATA_W-1:0] cdb_data;

	// stimulus lines
	int                 s_test [$];
	isa_pkg::op_t       s_op   [$];
	logic [`DATA_W-1:0] s_a    [$];
	logic [`DATA_W-1:0] s_b    [$];
	cdb_pkg::tag_t      s_tag  [$];
	logic [`DATA_W-1:0] s_exp  [$];

	// results still owed by the dut
	int                 p_due  [$];
	cdb_pkg::tag_t      p_tag  [$];
	logic [`DATA_W-1:0] p_data [$];

	int                 cyc;
	int                 checks;
	int                 errors;
	int                 err_mark;
	int                 tests_run;
	int                 failed_tests;
	int                 limit;
	int                 idx;
	int                 first;
	bit                 took;
	logic [`DATA_W-1:0] cur_exp;

	cdb_core u_cdb_core (
		.clk         (clk),
		.arst_n      (arst_n),
		.issue_valid (issue_valid),
		.issue_op    (issue_op),
		.issue_a     (issue_a),
		.issue_b     (issue_b),
		.issue_tag   (issue_tag),
		.issue_ready (issue_ready),
		.cdb_valid   (cdb_valid),
		.cdb_tag     (cdb_tag),
		.cdb_data    (cdb_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic compare(input string name, input logic [`DATA_W-1:0] got,
		input logic [`DATA_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic load_stim();
		int                 fd;
		int                 n;
		int                 num;
		string              line;
		string              name;
		isa_pkg::op_t       op;
		logic [`DATA_W-1:0] a;
		logic [`DATA_W-1:0] b;
		logic [`DATA_W-1:0] tag;
		logic [`DATA_W-1:0] exp;
		fd = $fopen("verif/cdb_stim.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open verif/cdb_stim.txt, no operations will run");
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			n = $sscanf(line, "%d %s %h %h %h %h", num, name, a, b, tag, exp);
			case (name)
				"add":   op = isa_pkg::OP_ADD;
				"sub":   op = isa_pkg::OP_SUB;
				"mov":   op = isa_pkg::OP_MOV;
				"mul":   op = isa_pkg::OP_MUL;
				default: n = 0;
			endcase
			if (n != 6) begin
				errors++;
				$display("stimulus line not understood: %s", line);
				continue;
			end
			s_test.push_back(num);
			s_op.push_back(op);
			s_a.push_back(a);
			s_b.push_back(b);
			s_tag.push_back(tag[`TAG_W-1:0]);
			s_exp.push_back(exp);
		end
		$fclose(fd);
	endtask

	////////////////////
	// per-edge checking
	////////////////////

	task automatic tick();
		int                 hits;
		logic               want_ready;
		cdb_pkg::tag_t      tag_q;
		logic [`DATA_W-1:0] data_q;
		// values for the coming edge are settled by the falling edge
		@(negedge clk);
		cyc++;
		hits = 0;
		// oldest due item is the one left in tag_q and data_q
		for (int i = p_due.size() - 1; i >= 0; i--) begin
			if (p_due[i] <= cyc) begin
				hits++;
				tag_q  = p_tag[i];
				data_q = p_data[i];
				p_due.delete(i);
				p_tag.delete(i);
				p_data.delete(i);
			end
		end
		compare("cdb_valid", cdb_valid, hits > 0);
		if (hits > 0 && cdb_valid === 1'b1) begin
			compare("cdb_tag", cdb_tag, tag_q);
			compare("cdb_data", cdb_data, data_q);
		end
		if (hits > 1) begin
			errors++;
			$display("two results were due in one cdb slot at %0t ns, one is lost", $time);
		end
		took = 1'b0;
		if (issue_valid) begin
			// an alu op may not land on a slot already booked
			want_ready = 1'b1;
			if (issue_op != isa_pkg::OP_MUL) begin
				foreach (p_due[i]) begin
					if (p_due[i] == cyc + `ALU_LAT) begin
						want_ready = 1'b0;
					end
				end
			end
			compare("issue_ready", issue_ready, want_ready);
			if (issue_ready === 1'b1) begin
				took = 1'b1;
				p_due.push_back(cyc + (issue_op == isa_pkg::OP_MUL ? `MUL_LAT : `ALU_LAT));
				p_tag.push_back(issue_tag);
				p_data.push_back(cur_exp);
			end
		end
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	// ready for both unit kinds and a quiet cdb
	task automatic probe_idle();
		issue_op = isa_pkg::OP_ADD;
		#1;
		compare("issue_ready", issue_ready, 1'b1);
		issue_op = isa_pkg::OP_MUL;
		#1;
		compare("issue_ready", issue_ready, 1'b1);
		compare("cdb_valid", cdb_valid, 1'b0);
	endtask

	task automatic report_test(input string name, input int ops);
		tests_run++;
		if (errors == err_mark) begin
			$display("test %s: %0d operations, passed", name, ops);
		end else begin
			failed_tests++;
			$display("test %s: %0d operations, %0d errors", name, ops, errors - err_mark);
		end
		err_mark = errors;
	endtask

	initial begin
		arst_n       = 1'b0;
		issue_valid  = 1'b0;
		issue_op     = isa_pkg::OP_ADD;
		issue_a      = '0;
		issue_b      = '0;
		issue_tag    = '0;
		cur_exp      = '0;
		cyc          = 0;
		checks       = 0;
		errors       = 0;
		tests_run    = 0;
		failed_tests = 0;
		void'($urandom(32'hb749));
		load_stim();
		err_mark = errors;
		limit = (s_test.size() + RST_CYCLES) * (`MUL_LAT + MAX_GAP + 2);
		fork
			begin
				repeat (limit) @(posedge clk);
				$display("timeout, the run did not finish within %0d cycles", limit);
				$display("Checks failed");
				$finish;
			end
		join_none

		////////////////////
		// reset
		////////////////////

		repeat (RST_CYCLES - 1) begin
			@(posedge clk);
			#DRIVE_DLY;
			probe_idle();
		end
		@(posedge clk);
		#DRIVE_DLY;
		arst_n = 1'b1;
		probe_idle();
		repeat (2) tick();
		report_test("reset", 0);

		// ops of one test go back to back before the cdb drains
		idx = 0;
		while (idx < s_test.size()) begin
			first = idx;
			repeat ($urandom % (MAX_GAP + 1)) tick();
			while (idx < s_test.size() && s_test[idx] == s_test[first]) begin
				issue_valid = 1'b1;
				issue_op    = s_op[idx];
				issue_a     = s_a[idx];
				issue_b     = s_b[idx];
				issue_tag   = s_tag[idx];
				cur_exp     = s_exp[idx];
				tick();
				while (!took) begin
					tick();
				end
				issue_valid = 1'b0;
				idx++;
			end
			while (p_due.size() > 0) begin
				tick();
			end
			report_test($sformatf("%0d", s_test[first]), idx - first);
		end

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- verif/cdb_stim.txt
# test op a b tag expected; all hex except the decimal test number
# same test number issues back to back; expected is the low 32 bits of the result
1 add 00000005 00000003 1 00000008
1 sub 00000003 00000005 2 fffffffe
1 mov 12345678 cafef00d 3 cafef00d
1 add ffffffff 00000002 4 00000001
1 sub 00000000 00000001 5 ffffffff
2 mul 00000007 00000006 6 0000002a
3 mul ffffffff ffffffff 7 00000001
4 mul 00000003 00000005 8 0000000f
4 mul 00010000 00010000 9 00000000
4 mul 12345678 00000010 a 23456780
4 mul fffffffe 00000003 b fffffffa
5 mul 00000009 00000009 c 00000051
5 add 00000010 00000020 d 00000030
5 sub 00000064 00000001 e 00000063
6 mul 0000abcd 00000100 f 00abcd00
6 mov 00000000 0000beef 0 0000beef
7 mul 00000002 80000000 1 00000000
7 mul 00000003 80000001 2 80000003
7 add 00000001 00000001 3 00000002
8 add 11111111 22222222 4 33333333
8 mul 00001000 00001000 5 01000000
8 sub 00000000 ffffffff 6 00000001
8 mov deadbeef 00000042 7 00000042
8 mul 0000ffff 0000ffff 8 fffe0001

//--- flist.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/cdb_pkg.sv
verilog/issue_dispatch.sv
verilog/cdb_reservation.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/cdb_core.sv
verif/cdb_core_properties.sv
verif/cdb_core_tb.sv
